/* sim.f */
video_pkg.sv
line_timing.sv
sync_luma.sv
sine_rom.sv
chroma_gen.sv
comp_encoder.sv
comp_encoder_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module comp_encoder_tb -o comp_encoder_sim

out=$(./obj_dir/comp_encoder_sim)
echo "$out"

if echo "$out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1

/* comp_encoder_tb.sv */
`timescale 1ns/100ps

module comp_encoder_tb;
    import video_pkg::*;

    localparam int BURST_CYCLES = 9;
    localparam int BURST_LEN    = 16 * BURST_CYCLES;
    localparam int NUM_ROWS     = 17;

    // one sweep of raster_x
    // color 16 draws a random color per pixel
    typedef struct packed {
        chip_t       chip;
        logic [8:0]  y;
        logic [9:0]  x_start;
        logic [10:0] x_count;
        logic [4:0]  color;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        // burst on a blank pal line then the same line without a second burst
        '{PAL,       9'd305, 10'd440, 11'd200, 5'd2},
        '{PAL,       9'd305, 10'd0,   11'd504, 5'd16},
        // active lines for both standards
        '{NTSC_R8,   9'd100, 10'd0,   11'd520, 5'd16},
        '{PAL,       9'd200, 10'd0,   11'd504, 5'd16},
        '{UNUSED,    9'd201, 10'd0,   11'd504, 5'd16},
        // ntsc vertical sync window lines 0 to 8
        '{NTSC_R8,   9'd14,  10'd0,   11'd520, 5'd1},
        '{NTSC_R8,   9'd15,  10'd0,   11'd520, 5'd3},
        '{NTSC_R56A, 9'd16,  10'd0,   11'd520, 5'd16},
        '{NTSC_R8,   9'd17,  10'd0,   11'd520, 5'd7},
        '{NTSC_R56A, 9'd18,  10'd0,   11'd520, 5'd16},
        '{NTSC_R8,   9'd19,  10'd0,   11'd520, 5'd9},
        '{NTSC_R8,   9'd20,  10'd0,   11'd520, 5'd16},
        '{NTSC_R56A, 9'd21,  10'd0,   11'd520, 5'd5},
        '{NTSC_R8,   9'd22,  10'd0,   11'd520, 5'd16},
        // a few pal sync lines
        '{PAL,       9'd301, 10'd0,   11'd504, 5'd16},
        '{PAL,       9'd303, 10'd0,   11'd504, 5'd4},
        '{PAL,       9'd309, 10'd0,   11'd504, 5'd16}
    };

    logic        clk_col16x;
    logic        rst;
    chip_t       chip;
    logic [9:0]  raster_x;
    logic [8:0]  raster_y;
    logic [3:0]  pixel_color;
    logic        csync;
    logic [5:0]  luma;
    logic [5:0]  chroma;
    logic        native_active;

    // reference model state
    logic        checks_on = 1'b0;
    logic        exp_csync;
    logic [5:0]  exp_luma;
    logic [5:0]  chroma_pipe [0:2];
    logic [3:0]  ref_phase;
    burst_state_t ref_state;
    int          ref_left;
    logic [8:0]  ref_prev_y;
    timing_t     ref_t;
    logic        ref_active;
    logic        ref_in_burst;
    logic [2:0]  ref_amp;
    logic [7:0]  ref_offset;
    logic [7:0]  ref_wave;
    logic [8:0]  ref_sample;
    int          error_count = 0;
    int          check_count = 0;

    comp_encoder #(
        .BURST_CYCLES (BURST_CYCLES)
    ) dut_i (
        .clk_col16x    (clk_col16x),
        .rst           (rst),
        .chip          (chip),
        .raster_x      (raster_x),
        .raster_y      (raster_y),
        .pixel_color   (pixel_color),
        .csync         (csync),
        .luma          (luma),
        .chroma        (chroma),
        .native_active (native_active)
    );

    always #50 clk_col16x = ~clk_col16x;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic is_active_pixel(input chip_t c, input logic [9:0] x,
                                             input logic [8:0] y);
        timing_t t;
        t = timing_of(c);
        return ((x < t.hsync_start) || (x >= t.hvisible_start)) &&
               ((y < t.vblank_start) || (y > t.vblank_end));
    endfunction

    // expected {csync, luma} for one pixel before the output register
    function automatic logic [6:0] sync_and_luma(input chip_t c, input logic [9:0] x,
                                                 input logic [8:0] y, input logic [3:0] color);
        timing_t    t;
        int         half;
        int         pos;
        int         dy;
        logic       cs;
        logic [5:0] lv;
        t    = timing_of(c);
        half = int'(t.half_line);
        // distance from hsync start wrapped to a line and folded to a half line
        pos  = ((int'(x) - int'(t.hsync_start)) % (2 * half) + 2 * half) % (2 * half);
        pos  = pos % half;
        dy   = int'(y) - int'(t.vblank_start);
        if ((dy >= 0) && (dy <= 8))
        begin
            if ((dy >= 3) && (dy <= 5))
                cs = !(pos < half - int'(SERR_GAP));
            else
                cs = !(pos < int'(EQ_WIDTH));
            lv = cs ? BLANK_LEVEL : 6'd0;
        end
        else
        begin
            cs = !((x >= t.hsync_start) && (x < t.hsync_end));
            if (!cs)
                lv = 6'd0;
            else if (is_active_pixel(c, x, y))
                lv = LUMA_TABLE[color];
            else
                lv = BLANK_LEVEL;
        end
        return {cs, lv};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // model sees the same inputs as the DUT at each rising edge
    always @(posedge clk_col16x)
    begin
        checks_on = 1'b1;
        if (rst)
        begin
            exp_csync      = 1'b0;
            exp_luma       = 6'd0;
            chroma_pipe[0] = CHROMA_ZERO;
            chroma_pipe[1] = CHROMA_ZERO;
            chroma_pipe[2] = CHROMA_ZERO;
            ref_phase      = 4'd0;
            ref_state      = IDLE;
            ref_left       = 0;
            ref_prev_y     = 9'd0;
        end
        else
        begin
            {exp_csync, exp_luma} = sync_and_luma(chip, raster_x, raster_y, pixel_color);
            ref_t        = timing_of(chip);
            ref_active   = is_active_pixel(chip, raster_x, raster_y);
            ref_in_burst = (ref_state == BURST) ||
                           ((ref_state == ARMED) && (raster_x >= ref_t.burst_start));
            if (ref_active)
                ref_amp = AMP_TABLE[pixel_color];
            else if (ref_in_burst)
                ref_amp = AMP_BURST;
            else
                ref_amp = AMP_NONE;
            // phase offset only on active pixels
            if (!ref_active)
                ref_offset = 8'd0;
            else if ((chip == PAL) || (chip == UNUSED))
                ref_offset = PHASE_TABLE_PAL[pixel_color];
            else
                ref_offset = PHASE_TABLE_NTSC[pixel_color];
            ref_wave   = {ref_phase, 4'b0000} + ref_offset;
            ref_sample = sine_entry({ref_amp, ref_wave});
            chroma_pipe[2] = chroma_pipe[1];
            chroma_pipe[1] = chroma_pipe[0];
            chroma_pipe[0] = (ref_amp == AMP_NONE) ? CHROMA_ZERO : ref_sample[8:3];
            // burst sequence armed by a new line and BURST_LEN samples long
            if ((ref_state == IDLE) && (raster_y != ref_prev_y))
            begin
                ref_state = ARMED;
            end
            else if ((ref_state == ARMED) && ref_in_burst)
            begin
                ref_state = BURST;
                ref_left  = BURST_LEN - 1;
            end
            else if (ref_state == BURST)
            begin
                if (ref_left == 1)
                    ref_state = IDLE;
                ref_left--;
            end
            ref_prev_y = raster_y;
            ref_phase  = ref_phase + 4'd1;
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk_col16x)
    begin
        if (checks_on)
        begin
            check_value("csync", csync, exp_csync);
            check_value("luma", luma, exp_luma);
            check_value("chroma", chroma, chroma_pipe[2]);
            check_value("native_active", native_active,
                        is_active_pixel(chip, raster_x, raster_y));
        end
    end

    initial
    begin
        logic [31:0] rng;
        rng         = 32'd86;
        clk_col16x  = 1'b0;
        rst         = 1'b1;
        chip        = NTSC_R8;
        raster_x    = 10'd0;
        raster_y    = 9'd0;
        pixel_color = 4'd0;
        repeat (4) @(posedge clk_col16x);
        rst <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            for (int i = 0; i < int'(ROWS[r].x_count); i++)
            begin
                @(posedge clk_col16x);
                chip     <= ROWS[r].chip;
                raster_y <= ROWS[r].y;
                raster_x <= 10'(int'(ROWS[r].x_start) + i);
                if (ROWS[r].color[4])
                begin
                    rng = next_random(rng);
                    pixel_color <= rng[3:0];
                end
                else
                begin
                    pixel_color <= ROWS[r].color[3:0];
                end
            end
        end
        // let the chroma pipeline drain
        repeat (4) @(posedge clk_col16x);
        @(negedge clk_col16x);
        #1;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // watchdog at twice the sweep length plus reset and drain
    initial
    begin
        int total;
        total = 16;
        for (int r = 0; r < NUM_ROWS; r++)
            total += int'(ROWS[r].x_count);
        #(total * 200);
        $display("timeout: the stimulus sweep did not finish in time");
        $display("Test failures found");
        $finish;
    end

endmodule

/* comp_encoder.sv */
`timescale 1ns/100ps

module comp_encoder #(
    parameter int BURST_CYCLES = 9
) (
    input  logic             clk_col16x,
    input  logic             rst,
    input  video_pkg::chip_t chip,
    input  logic [9:0]       raster_x,
    input  logic [8:0]       raster_y,
    input  logic [3:0]       pixel_color,
    output logic             csync,
    output logic [5:0]       luma,
    output logic [5:0]       chroma,
    output logic             native_active
);

    logic        hsync;
    logic        eq_pulse;
    logic        se_pulse;
    logic [3:0]  vsync_line;
    logic [9:0]  burst_start;
    logic [10:0] sine_addr;
    logic [8:0]  sine_data;

    // window and pulse decode
    line_timing timing_i (
        .chip          (chip),
        .raster_x      (raster_x),
        .raster_y      (raster_y),
        .native_active (native_active),
        .hsync         (hsync),
        .eq_pulse      (eq_pulse),
        .se_pulse      (se_pulse),
        .vsync_line    (vsync_line),
        .burst_start   (burst_start)
    );

    sync_luma sync_luma_i (
        .clk_col16x    (clk_col16x),
        .rst           (rst),
        .pixel_color   (pixel_color),
        .native_active (native_active),
        .hsync         (hsync),
        .eq_pulse      (eq_pulse),
        .se_pulse      (se_pulse),
        .vsync_line    (vsync_line),
        .csync         (csync),
        .luma          (luma)
    );

    chroma_gen #(
        .BURST_CYCLES (BURST_CYCLES)
    ) chroma_i (
        .clk_col16x    (clk_col16x),
        .rst           (rst),
        .chip          (chip),
        .raster_y      (raster_y),
        .raster_x      (raster_x),
        .burst_start   (burst_start),
        .pixel_color   (pixel_color),
        .native_active (native_active),
        .sine_data     (sine_data),
        .sine_addr     (sine_addr),
        .chroma        (chroma)
    );

    sine_rom rom_i (
        .clk_col16x (clk_col16x),
        .addr       (sine_addr),
        .data       (sine_data)
    );

endmodule

/* chroma_gen.sv */
`timescale 1ns/100ps

module chroma_gen #(
    parameter int BURST_CYCLES = 9
) (
    input  logic             clk_col16x,
    input  logic             rst,
    input  video_pkg::chip_t chip,
    input  logic [8:0]       raster_y,
    input  logic [9:0]       raster_x,
    input  logic [9:0]       burst_start,
    input  logic [3:0]       pixel_color,
    input  logic             native_active,
    input  logic [8:0]       sine_data,
    output logic [10:0]      sine_addr,
    output logic [5:0]       chroma
);
    import video_pkg::*;

    // 16 samples per color clock period
    localparam int BURST_LEN = 16 * BURST_CYCLES;
    localparam int CNT_W     = $clog2(BURST_LEN);

    burst_state_t     state;
    logic [CNT_W-1:0] burst_cnt;
    logic [8:0]       prev_raster_y;
    logic [3:0]       phase_cnt;
    logic             burst_go;
    logic             in_burst;
    logic [2:0]       amp_sel;
    logic [2:0]       amp_d1;
    logic [2:0]       amp_d2;
    logic [7:0]       phase_off;
    logic [7:0]       wave_addr;

    // free running, one step per sample
    always_ff @(posedge clk_col16x)
    begin
        if (rst)
            phase_cnt <= 4'd0;
        else
            phase_cnt <= phase_cnt + 4'd1;
    end

    // first burst sample is the armed cycle that reaches burst_start
    assign burst_go = (state == ARMED) && (raster_x >= burst_start);
    assign in_burst = burst_go || (state == BURST);

    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            state         <= IDLE;
            burst_cnt     <= '0;
            prev_raster_y <= 9'd0;
        end
        else
        begin
            prev_raster_y <= raster_y;
            case (state)
                IDLE:
                begin
                    // new line arms the burst
                    if (raster_y != prev_raster_y)
                        state <= ARMED;
                end
                ARMED:
                begin
                    if (burst_go)
                    begin
                        state     <= BURST;
                        burst_cnt <= CNT_W'(1);
                    end
                end
                BURST:
                begin
                    if (burst_cnt == CNT_W'(BURST_LEN - 1))
                    begin
                        state     <= IDLE;
                        burst_cnt <= '0;
                    end
                    else
                    begin
                        burst_cnt <= burst_cnt + 1'b1;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // per-color lookups, phase table depends on the standard
    assign phase_off = ((chip == PAL) || (chip == UNUSED)) ?
                       PHASE_TABLE_PAL[pixel_color] : PHASE_TABLE_NTSC[pixel_color];

    always_comb
    begin
        if (native_active)
            amp_sel = AMP_TABLE[pixel_color];
        else if (in_burst)
            amp_sel = AMP_BURST;
        else
            amp_sel = AMP_NONE;
    end

    // burst and blanking use zero phase offset
    assign wave_addr = {phase_cnt, 4'b0000} + (native_active ? phase_off : 8'd0);

    // stage 1 rom address, stage 2 rom data, stage 3 output
    always_ff @(posedge clk_col16x)
    begin
        sine_addr <= {amp_sel, wave_addr};
    end

    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            amp_d1 <= AMP_NONE;
            amp_d2 <= AMP_NONE;
            chroma <= CHROMA_ZERO;
        end
        else
        begin
            // amplitude follows the rom pipeline
            amp_d1 <= amp_sel;
            amp_d2 <= amp_d1;
            chroma <= (amp_d2 == AMP_NONE) ? CHROMA_ZERO : sine_data[8:3];
        end
    end

endmodule

/* sine_rom.sv */
`timescale 1ns/100ps

module sine_rom (
    input  logic        clk_col16x,
    input  logic [10:0] addr,
    output logic [8:0]  data
);
    import video_pkg::*;

    // eight amplitudes of 256 samples each
    logic [8:0] rom [0:2047];

    initial
    begin
        for (int i = 0; i < 2048; i++)
        begin
            rom[i] = sine_entry(11'(i));
        end
    end

    // registered read, one cycle of latency
    always_ff @(posedge clk_col16x)
    begin
        data <= rom[addr];
    end

endmodule

/* sync_luma.sv */
`timescale 1ns/100ps

module sync_luma (
    input  logic       clk_col16x,
    input  logic       rst,
    input  logic [3:0] pixel_color,
    input  logic       native_active,
    input  logic       hsync,
    input  logic       eq_pulse,
    input  logic       se_pulse,
    input  logic [3:0] vsync_line,
    output logic       csync,
    output logic [5:0] luma
);
    import video_pkg::*;

    logic       csync_next;
    logic [5:0] luma_next;

    always_comb
    begin
        case (vsync_line)
            // equalization lines before and after the broad pulses
            4'd0, 4'd1, 4'd2, 4'd6, 4'd7, 4'd8:
            begin
                csync_next = ~eq_pulse;
                luma_next  = eq_pulse ? 6'd0 : BLANK_LEVEL;
            end
            // serrated vertical sync lines
            4'd3, 4'd4, 4'd5:
            begin
                csync_next = ~se_pulse;
                luma_next  = se_pulse ? 6'd0 : BLANK_LEVEL;
            end
            default:
            begin
                csync_next = ~hsync;
                if (hsync)
                    luma_next = 6'd0;
                else if (native_active)
                    luma_next = LUMA_TABLE[pixel_color];
                else
                    luma_next = BLANK_LEVEL;
            end
        endcase
    end

    always_ff @(posedge clk_col16x)
    begin
        if (rst)
        begin
            csync <= 1'b0;
            luma  <= 6'd0;
        end
        else
        begin
            csync <= csync_next;
            luma  <= luma_next;
        end
    end

endmodule

/* line_timing.sv */
`timescale 1ns/100ps

module line_timing (
    input  video_pkg::chip_t chip,
    input  logic [9:0]       raster_x,
    input  logic [8:0]       raster_y,
    output logic             native_active,
    output logic             hsync,
    output logic             eq_pulse,
    output logic             se_pulse,
    output logic [3:0]       vsync_line,
    output logic [9:0]       burst_start
);
    import video_pkg::*;

    // vsync_line value for lines outside the vertical sync window
    localparam logic [3:0] VSYNC_OUT = 4'hf;

    timing_t     t;
    logic [10:0] line_len;
    logic [10:0] half;
    logic [10:0] rel;
    logic [10:0] pos;
    logic [8:0]  dy;

    assign t = timing_of(chip);

    // horizontal windows
    assign hsync = (raster_x >= t.hsync_start) && (raster_x < t.hsync_end);

    // active outside horizontal blank and outside vertical blank
    assign native_active = ((raster_x < t.hsync_start) || (raster_x >= t.hvisible_start)) &&
                           ((raster_y < t.vblank_start) || (raster_y > t.vblank_end));

    assign burst_start = t.burst_start;

    // pulse trains repeat every half line, line length is two halves
    assign half     = {1'b0, t.half_line};
    assign line_len = {t.half_line, 1'b0};

    always_comb
    begin
        // position relative to hsync start, wrapped to one line
        if (raster_x >= t.hsync_start)
        begin
            rel = {1'b0, raster_x} - {1'b0, t.hsync_start};
        end
        else
        begin
            rel = {1'b0, raster_x} + line_len - {1'b0, t.hsync_start};
        end
        if (rel >= line_len)
        begin
            rel = rel - line_len;
        end

        // fold second half onto the first
        if (rel >= half)
        begin
            pos = rel - half;
        end
        else
        begin
            pos = rel;
        end
    end

    // short equalization pulse, long serration pulse
    assign eq_pulse = pos < {1'b0, EQ_WIDTH};
    assign se_pulse = pos < (half - {1'b0, SERR_GAP});

    // line within vsync, below vblank_start wraps to a large value
    assign dy         = raster_y - t.vblank_start;
    assign vsync_line = (dy <= 9'd8) ? dy[3:0] : VSYNC_OUT;

endmodule

/* video_pkg.sv */
package video_pkg;

    // chip variants
    // UNUSED falls back to PAL timing
    typedef enum logic [1:0] {
        NTSC_R8   = 2'd0,
        NTSC_R56A = 2'd1,
        PAL       = 2'd2,
        UNUSED    = 2'd3
    } chip_t;

    // chroma burst sequencing
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ARMED = 2'd1,
        BURST = 2'd2
    } burst_state_t;

    // one set of line and frame timing in raster counts
    typedef struct packed {
        logic [9:0] hsync_start;
        logic [9:0] hsync_end;
        logic [9:0] hvisible_start;
        logic [9:0] burst_start;
        logic [8:0] vblank_start;
        logic [8:0] vblank_end;
        logic [9:0] half_line;
    } timing_t;

    // ntsc timing with one x count of roughly 122 ns
    localparam timing_t NTSC_TIMING = '{
        hsync_start:    10'd409,
        hsync_end:      10'd446,
        hvisible_start: 10'd497,
        burst_start:    10'd451,
        vblank_start:   9'd14,
        vblank_end:     9'd22,
        half_line:      10'd260
    };

    // pal timing with one x count of roughly 127 ns
    localparam timing_t PAL_TIMING = '{
        hsync_start:    10'd408,
        hsync_end:      10'd444,
        hvisible_start: 10'd492,
        burst_start:    10'd449,
        vblank_start:   9'd301,
        vblank_end:     9'd309,
        half_line:      10'd252
    };

    // vertical sync pulse widths in x counts
    localparam logic [9:0] EQ_WIDTH = 10'd18;
    localparam logic [9:0] SERR_GAP = 10'd37;

    // output levels
    localparam logic [5:0] BLANK_LEVEL = 6'd19;
    localparam logic [5:0] CHROMA_ZERO = 6'd32;

    // amplitude codes where 7 selects the flat table
    localparam logic [2:0] AMP_NONE  = 3'd7;
    localparam logic [2:0] AMP_BURST = 3'd2;

    // luma per color index
    localparam logic [5:0] LUMA_TABLE [0:15] = '{
        6'd19, 6'd63, 6'd32, 6'd48, 6'd36, 6'd43, 6'd28, 6'd55,
        6'd36, 6'd28, 6'd43, 6'd32, 6'd40, 6'd55, 6'd40, 6'd48
    };

    // amplitude per color index
    // greys carry no color
    localparam logic [2:0] AMP_TABLE [0:15] = '{
        3'd7, 3'd7, 3'd4, 3'd4, 3'd3, 3'd3, 3'd4, 3'd3,
        3'd3, 3'd4, 3'd4, 3'd7, 3'd7, 3'd3, 3'd4, 3'd7
    };

    // phase offsets in 256 counts per color cycle
    localparam logic [7:0] PHASE_TABLE_NTSC [0:15] = '{
        8'd0,   8'd0,   8'd80,  8'd208, 8'd32,  8'd160, 8'd0,   8'd128,
        8'd96,  8'd112, 8'd80,  8'd0,   8'd0,   8'd160, 8'd0,   8'd0
    };

    localparam logic [7:0] PHASE_TABLE_PAL [0:15] = '{
        8'd0,   8'd0,   8'd72,  8'd200, 8'd40,  8'd168, 8'd8,   8'd136,
        8'd104, 8'd120, 8'd72,  8'd0,   8'd0,   8'd168, 8'd8,   8'd0
    };

    localparam real TWO_PI = 6.283185307179586;

    function automatic timing_t timing_of(chip_t c);
        case (c)
            PAL, UNUSED: return PAL_TIMING;
            default:     return NTSC_TIMING;
        endcase
    endfunction

    // top 3 address bits pick the amplitude and the low 8 bits the angle
    function automatic logic [8:0] sine_entry(logic [10:0] addr);
        real amp;
        real angle;
        int  val;
        amp   = real'(7 - int'(addr[10:8])) * 36.0;
        angle = TWO_PI * real'(addr[7:0]) / 256.0;
        // int cast rounds to nearest
        val   = 256 + int'(amp * $sin(angle));
        return val[8:0];
    endfunction

endpackage
